// File: verilog/sram_pkg.sv
`default_nettype none

package sram_pkg;

    // Bank geometry
    localparam int BANK_WORDS = 256;
    localparam int ADDR_W     = $clog2(BANK_WORDS);
    localparam int DATA_W     = 32;
    localparam int MASK_W     = DATA_W / 8;

    typedef logic [ADDR_W-1:0] sram_addr_t;
    typedef logic [DATA_W-1:0] sram_data_t;
    typedef logic [MASK_W-1:0] sram_mask_t;

    // One bank, one cycle, both ports
    typedef struct packed {
        logic       rw_ena;
        logic       rw_write;
        sram_mask_t rw_mask;
        sram_addr_t rw_addr;
        sram_data_t rw_wdata;
        logic       ro_ena;
        sram_addr_t ro_addr;
    } bank_cmd_t;

    // Host request packet, bank_sel 0 picks bank 0
    typedef struct packed {
        logic      bank_sel;
        bank_cmd_t cmd;
    } mem_req_t;

    typedef struct packed {
        logic       rw_valid;
        sram_data_t rw_data;
        logic       ro_valid;
        sram_data_t ro_data;
    } mem_resp_t;

endpackage

`default_nettype wire

// File: verilog/sram_request_router.sv
`timescale 1ns/1ps
`default_nettype none

module sram_request_router import sram_pkg::*; #(
    parameter int QUEUE_DEPTH      = 4,
    parameter int MAX_RESP_CREDITS = 8
) (
    input  logic      clk_in,
    input  logic      arst_n,
    input  logic      req_valid,
    input  mem_req_t  req,
    input  logic      resp_credit,
    output logic      req_credit,
    output bank_cmd_t bank_cmd0,
    output bank_cmd_t bank_cmd1,
    output logic      issue_valid,
    output logic      issue_bank,
    output logic      issue_rw_read,
    output logic      issue_ro_read
);

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);
    localparam int CRD_W = $clog2(MAX_RESP_CREDITS + 1);

    mem_req_t         queue [QUEUE_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic [CRD_W-1:0] credits;

    mem_req_t head;
    logic     head_rw_read;
    logic     head_ro_read;
    logic     head_reads;
    logic     push;
    logic     pop;

    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(QUEUE_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign head         = queue[rd_ptr];
    assign head_rw_read = head.cmd.rw_ena & ~head.cmd.rw_write;
    assign head_ro_read = head.cmd.ro_ena;
    assign head_reads   = head_rw_read | head_ro_read;

    // Host only sends with a credit in hand, so no full check
    assign push = req_valid;

    // Reads wait for a response credit, writes and idle packets go straight out
    assign pop = (count != '0) && (!head_reads || (credits != '0));

    always_ff @(posedge clk_in) begin
        if (push) begin
            queue[wr_ptr] <= req;
        end
    end

    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            count <= count + CNT_W'(push) - CNT_W'(pop);
        end
    end

    // Response credits, spent when a read issues
    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            credits <= '0;
        end else begin
            credits <= credits + CRD_W'(resp_credit) - CRD_W'(pop & head_reads);
        end
    end

    // Steer the head to its bank, the other bank sees all zeros
    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            bank_cmd0     <= '0;
            bank_cmd1     <= '0;
            req_credit    <= 1'b0;
            issue_valid   <= 1'b0;
            issue_bank    <= 1'b0;
            issue_rw_read <= 1'b0;
            issue_ro_read <= 1'b0;
        end else begin
            bank_cmd0 <= '0;
            bank_cmd1 <= '0;
            if (pop) begin
                if (head.bank_sel) begin
                    bank_cmd1 <= head.cmd;
                end else begin
                    bank_cmd0 <= head.cmd;
                end
                issue_bank <= head.bank_sel;
            end
            req_credit    <= pop;
            issue_valid   <= pop & head_reads;
            issue_rw_read <= pop & head_rw_read;
            issue_ro_read <= pop & head_ro_read;
        end
    end

endmodule

`default_nettype wire

// File: verilog/sram_bank.sv
`timescale 1ns/1ps
`default_nettype none

module sram_bank import sram_pkg::*; (
    input  logic       clk_in,
    input  bank_cmd_t  cmd,
    output sram_data_t rw_rdata,
    output sram_data_t ro_rdata
);

    sram_data_t mem [BANK_WORDS];

    logic rw_wr;
    logic rw_rd;

    assign rw_wr = cmd.rw_ena & cmd.rw_write;
    assign rw_rd = cmd.rw_ena & ~cmd.rw_write;

    // Byte lanes written under mask
    always_ff @(posedge clk_in) begin
        if (rw_wr) begin
            for (int i = 0; i < MASK_W; i++) begin
                if (cmd.rw_mask[i]) begin
                    mem[cmd.rw_addr][8*i +: 8] <= cmd.rw_wdata[8*i +: 8];
                end
            end
        end
    end

    // RW port read, holds last value when idle
    always_ff @(posedge clk_in) begin
        if (rw_rd) begin
            rw_rdata <= mem[cmd.rw_addr];
        end
    end

    // RO port sees the word from before a same-cycle write
    always_ff @(posedge clk_in) begin
        if (cmd.ro_ena) begin
            ro_rdata <= mem[cmd.ro_addr];
        end
    end

endmodule

`default_nettype wire

// File: verilog/sram_read_merge.sv
`timescale 1ns/1ps
`default_nettype none

module sram_read_merge import sram_pkg::*; (
    input  logic       clk_in,
    input  logic       arst_n,
    input  logic       issue_valid,
    input  logic       issue_bank,
    input  logic       issue_rw_read,
    input  logic       issue_ro_read,
    input  sram_data_t bank0_rw_rdata,
    input  sram_data_t bank0_ro_rdata,
    input  sram_data_t bank1_rw_rdata,
    input  sram_data_t bank1_ro_rdata,
    output logic       resp_valid,
    output mem_resp_t  resp
);

    logic dly_valid;
    logic dly_bank;
    logic dly_rw_read;
    logic dly_ro_read;

    // Line up with the bank read data
    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            dly_valid   <= 1'b0;
            dly_bank    <= 1'b0;
            dly_rw_read <= 1'b0;
            dly_ro_read <= 1'b0;
        end else begin
            dly_valid   <= issue_valid;
            dly_bank    <= issue_bank;
            dly_rw_read <= issue_rw_read;
            dly_ro_read <= issue_ro_read;
        end
    end

    // Pick the bank this read went to
    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            resp_valid <= 1'b0;
            resp       <= '0;
        end else begin
            resp_valid    <= dly_valid;
            resp.rw_valid <= dly_valid & dly_rw_read;
            resp.ro_valid <= dly_valid & dly_ro_read;
            resp.rw_data  <= dly_bank ? bank1_rw_rdata : bank0_rw_rdata;
            resp.ro_data  <= dly_bank ? bank1_ro_rdata : bank0_ro_rdata;
        end
    end

endmodule

`default_nettype wire

// File: verilog/sram_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module sram_subsystem import sram_pkg::*; #(
    parameter int QUEUE_DEPTH      = 4,
    parameter int MAX_RESP_CREDITS = 8
) (
    input  logic      clk_in,
    input  logic      arst_n,
    input  logic      req_valid,
    input  mem_req_t  req,
    input  logic      resp_credit,
    output logic      req_credit,
    output logic      resp_valid,
    output mem_resp_t resp
);

    bank_cmd_t  bank_cmd0;
    bank_cmd_t  bank_cmd1;
    logic       issue_valid;
    logic       issue_bank;
    logic       issue_rw_read;
    logic       issue_ro_read;
    sram_data_t bank0_rw_rdata;
    sram_data_t bank0_ro_rdata;
    sram_data_t bank1_rw_rdata;
    sram_data_t bank1_ro_rdata;

    sram_request_router #(
        .QUEUE_DEPTH      (QUEUE_DEPTH),
        .MAX_RESP_CREDITS (MAX_RESP_CREDITS)
    ) u_router (
        .clk_in        (clk_in),
        .arst_n        (arst_n),
        .req_valid     (req_valid),
        .req           (req),
        .resp_credit   (resp_credit),
        .req_credit    (req_credit),
        .bank_cmd0     (bank_cmd0),
        .bank_cmd1     (bank_cmd1),
        .issue_valid   (issue_valid),
        .issue_bank    (issue_bank),
        .issue_rw_read (issue_rw_read),
        .issue_ro_read (issue_ro_read)
    );

    sram_bank u_bank0 (
        .clk_in   (clk_in),
        .cmd      (bank_cmd0),
        .rw_rdata (bank0_rw_rdata),
        .ro_rdata (bank0_ro_rdata)
    );

    sram_bank u_bank1 (
        .clk_in   (clk_in),
        .cmd      (bank_cmd1),
        .rw_rdata (bank1_rw_rdata),
        .ro_rdata (bank1_ro_rdata)
    );

    sram_read_merge u_merge (
        .clk_in         (clk_in),
        .arst_n         (arst_n),
        .issue_valid    (issue_valid),
        .issue_bank     (issue_bank),
        .issue_rw_read  (issue_rw_read),
        .issue_ro_read  (issue_ro_read),
        .bank0_rw_rdata (bank0_rw_rdata),
        .bank0_ro_rdata (bank0_ro_rdata),
        .bank1_rw_rdata (bank1_rw_rdata),
        .bank1_ro_rdata (bank1_ro_rdata),
        .resp_valid     (resp_valid),
        .resp           (resp)
    );

endmodule

`default_nettype wire

// File: test/sram_subsystem_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module sram_subsystem_assertions import sram_pkg::*; (
    input logic      clk_in,
    input logic      arst_n,
    input bank_cmd_t bank_cmd0,
    input bank_cmd_t bank_cmd1,
    input logic      req_credit,
    input logic      resp_credit,
    input logic      issue_valid,
    input logic      resp_valid,
    input mem_resp_t resp
);

    logic        bank0_busy;
    logic        bank1_busy;
    int unsigned credits_granted;
    int unsigned reads_issued;

    int steer_fails  = 0;
    int resp_fails   = 0;
    int reset_fails  = 0;
    int credit_fails = 0;
    int fail_count;

    assign bank0_busy = bank_cmd0.rw_ena | bank_cmd0.ro_ena;
    assign bank1_busy = bank_cmd1.rw_ena | bank_cmd1.ro_ena;
    assign fail_count = steer_fails + resp_fails + reset_fails + credit_fails;

    // Running totals of granted credits and issued reads
    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            credits_granted <= 0;
            reads_issued    <= 0;
        end else begin
            if (resp_credit) begin
                credits_granted <= credits_granted + 1;
            end
            if (issue_valid) begin
                reads_issued <= reads_issued + 1;
            end
        end
    end

    a_one_bank: assert property (@(posedge clk_in) disable iff (!arst_n)
        !(bank0_busy && bank1_busy))
    else begin
        steer_fails++;
        $error("both banks enabled in the same cycle");
    end

    a_resp_port: assert property (@(posedge clk_in) disable iff (!arst_n)
        resp_valid |-> (resp.rw_valid || resp.ro_valid))
    else begin
        resp_fails++;
        $error("response without a valid port");
    end

    a_reset_credit: assert property (@(posedge clk_in) $rose(arst_n) |=> !req_credit)
    else begin
        reset_fails++;
        $error("request credit right after reset");
    end

    a_read_credit: assert property (@(posedge clk_in) disable iff (!arst_n)
        reads_issued <= credits_granted)
    else begin
        credit_fails++;
        $error("more reads issued than response credits granted");
    end

endmodule

`default_nettype wire

// File: test/tb_sram_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_sram_subsystem import sram_pkg::*; ();

    localparam int QUEUE_DEPTH      = 4;
    localparam int MAX_RESP_CREDITS = 8;
    localparam int TIMEOUT          = 500;
    localparam int RANDOM_PACKETS   = 200;

    logic      clk_in;
    logic      arst_n;
    logic      req_valid;
    mem_req_t  req;
    logic      resp_credit;
    logic      req_credit;
    logic      resp_valid;
    mem_resp_t resp;

    // Host model state
    int         host_credits;
    int         resp_credits_out;
    int         resp_count;
    int         req_credit_count;
    mem_resp_t  exp_q[$];
    sram_data_t ref_mem0 [BANK_WORDS];
    sram_data_t ref_mem1 [BANK_WORDS];

    sram_subsystem #(
        .QUEUE_DEPTH      (QUEUE_DEPTH),
        .MAX_RESP_CREDITS (MAX_RESP_CREDITS)
    ) u_dut (
        .clk_in      (clk_in),
        .arst_n      (arst_n),
        .req_valid   (req_valid),
        .req         (req),
        .resp_credit (resp_credit),
        .req_credit  (req_credit),
        .resp_valid  (resp_valid),
        .resp        (resp)
    );

    bind sram_subsystem sram_subsystem_assertions u_sva (
        .clk_in      (clk_in),
        .arst_n      (arst_n),
        .bank_cmd0   (bank_cmd0),
        .bank_cmd1   (bank_cmd1),
        .req_credit  (req_credit),
        .resp_credit (resp_credit),
        .issue_valid (issue_valid),
        .resp_valid  (resp_valid),
        .resp        (resp)
    );

    always #4 clk_in = ~clk_in;

    task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("** Error at %0t ns: %s, got %0h, expected %0h", $time, what, actual,
                     expected);
            $display("Test failed");
            $fatal(1, "stopping at first error");
        end
    endtask

    task automatic fail_run(input string why);
        $display("Failure at %0t ns: %s", $time, why);
        $display("Test failed");
        $fatal(1, "stopping at first failure");
    endtask

    function automatic sram_data_t fill_word(input logic bank, input sram_addr_t addr);
        return {7'h5a, bank, addr, ~addr, addr ^ 8'hc3};
    endfunction

    function automatic sram_data_t ref_read(input logic bank, input sram_addr_t addr);
        return bank ? ref_mem1[addr] : ref_mem0[addr];
    endfunction

    function automatic void ref_write(input logic bank, input sram_addr_t addr,
                                      input sram_mask_t mask, input sram_data_t data);
        sram_data_t word;
        word = ref_read(bank, addr);
        for (int i = 0; i < MASK_W; i++) begin
            if (mask[i]) begin
                word[8*i +: 8] = data[8*i +: 8];
            end
        end
        if (bank) begin
            ref_mem1[addr] = word;
        end else begin
            ref_mem0[addr] = word;
        end
    endfunction

    function automatic mem_req_t make_req(input logic bank, input logic rw_ena,
                                          input logic rw_write, input sram_mask_t mask,
                                          input sram_addr_t rw_addr, input sram_data_t wdata,
                                          input logic ro_ena, input sram_addr_t ro_addr);
        mem_req_t r;
        r.bank_sel     = bank;
        r.cmd.rw_ena   = rw_ena;
        r.cmd.rw_write = rw_write;
        r.cmd.rw_mask  = mask;
        r.cmd.rw_addr  = rw_addr;
        r.cmd.rw_wdata = wdata;
        r.cmd.ro_ena   = ro_ena;
        r.cmd.ro_addr  = ro_addr;
        return r;
    endfunction

    task automatic pulse_resp_credit();
        resp_credit = 1'b1;
        resp_credits_out++;
        @(negedge clk_in);
        resp_credit = 1'b0;
    endtask

    // Reads are predicted before the write of the same packet lands
    task automatic send_req(input mem_req_t r);
        int        waited;
        mem_resp_t expected;
        waited = 0;
        while (host_credits == 0) begin
            if (resp_credits_out < exp_q.size()) begin
                pulse_resp_credit();
            end else begin
                @(negedge clk_in);
            end
            waited++;
            if (waited > TIMEOUT) begin
                fail_run("no request credit came back from the DUT");
            end
        end
        expected = '0;
        if (r.cmd.rw_ena && !r.cmd.rw_write) begin
            expected.rw_valid = 1'b1;
            expected.rw_data  = ref_read(r.bank_sel, r.cmd.rw_addr);
        end
        if (r.cmd.ro_ena) begin
            expected.ro_valid = 1'b1;
            expected.ro_data  = ref_read(r.bank_sel, r.cmd.ro_addr);
        end
        if (expected.rw_valid || expected.ro_valid) begin
            exp_q.push_back(expected);
        end
        if (r.cmd.rw_ena && r.cmd.rw_write) begin
            ref_write(r.bank_sel, r.cmd.rw_addr, r.cmd.rw_mask, r.cmd.rw_wdata);
        end
        req_valid = 1'b1;
        req       = r;
        host_credits--;
        @(negedge clk_in);
        req_valid = 1'b0;
    endtask

    task automatic drain(input string what);
        int waited;
        waited = 0;
        while (exp_q.size() != 0 || host_credits != QUEUE_DEPTH) begin
            if (resp_credits_out < exp_q.size()) begin
                pulse_resp_credit();
            end else begin
                @(negedge clk_in);
            end
            waited++;
            if (waited > TIMEOUT) begin
                fail_run({"DUT did not drain during ", what});
            end
        end
    endtask

    // Sample just before the DUT registers update
    always @(posedge clk_in) begin
        mem_resp_t exp_resp;
        if (arst_n) begin
            if (req_credit) begin
                host_credits++;
                req_credit_count++;
            end
            if (resp_valid) begin
                if (exp_q.size() == 0) begin
                    fail_run("response arrived with no read outstanding");
                end
                exp_resp = exp_q.pop_front();
                check_value(64'(resp.rw_valid), 64'(exp_resp.rw_valid), "rw_valid");
                check_value(64'(resp.ro_valid), 64'(exp_resp.ro_valid), "ro_valid");
                if (exp_resp.rw_valid) begin
                    check_value(64'(resp.rw_data), 64'(exp_resp.rw_data), "rw_data");
                end
                if (exp_resp.ro_valid) begin
                    check_value(64'(resp.ro_data), 64'(exp_resp.ro_data), "ro_data");
                end
                resp_credits_out--;
                resp_count++;
            end
        end
    end

    always @(negedge clk_in) begin
        if (u_dut.u_sva.fail_count != 0) begin
            fail_run("a bound assertion on the DUT failed");
        end
    end

    task automatic fill_banks();
        for (int b = 0; b < 2; b++) begin
            for (int a = 0; a < BANK_WORDS; a++) begin
                send_req(make_req(1'(b), 1'b1, 1'b1, 4'hf, 8'(a), fill_word(1'(b), 8'(a)),
                                  1'b0, 8'h00));
            end
        end
        drain("bank fill");
    endtask

    task automatic test_bank_isolation();
        send_req(make_req(1'b0, 1'b1, 1'b1, 4'hf, 8'h3c, 32'h0bad_0000, 1'b0, 8'h00));
        send_req(make_req(1'b1, 1'b1, 1'b1, 4'hf, 8'h3c, 32'h1bad_1111, 1'b0, 8'h00));
        send_req(make_req(1'b0, 1'b1, 1'b0, 4'h0, 8'h3c, 32'h0, 1'b0, 8'h00));
        send_req(make_req(1'b1, 1'b1, 1'b0, 4'h0, 8'h3c, 32'h0, 1'b0, 8'h00));
        drain("bank isolation");
    endtask

    task automatic test_byte_mask();
        send_req(make_req(1'b1, 1'b1, 1'b1, 4'b1111, 8'h81, 32'ha1b2c3d4, 1'b0, 8'h00));
        send_req(make_req(1'b1, 1'b1, 1'b0, 4'h0, 8'h81, 32'h0, 1'b0, 8'h00));
        send_req(make_req(1'b1, 1'b1, 1'b1, 4'b0001, 8'h81, 32'h11223344, 1'b0, 8'h00));
        send_req(make_req(1'b1, 1'b1, 1'b0, 4'h0, 8'h81, 32'h0, 1'b0, 8'h00));
        send_req(make_req(1'b1, 1'b1, 1'b1, 4'b0110, 8'h81, 32'h55667788, 1'b0, 8'h00));
        send_req(make_req(1'b1, 1'b1, 1'b0, 4'h0, 8'h81, 32'h0, 1'b0, 8'h00));
        send_req(make_req(1'b1, 1'b1, 1'b1, 4'b1000, 8'h81, 32'h99aabbcc, 1'b0, 8'h00));
        send_req(make_req(1'b1, 1'b1, 1'b0, 4'h0, 8'h81, 32'h0, 1'b0, 8'h00));
        check_value(64'(ref_read(1'b1, 8'h81)), 64'h99667744, "merged byte mask word");
        drain("byte mask");
    endtask

    task automatic test_dual_port_read();
        send_req(make_req(1'b0, 1'b1, 1'b0, 4'h0, 8'h10, 32'h0, 1'b1, 8'h20));
        // Write 0x20 while the RO port reads it, old word expected
        send_req(make_req(1'b0, 1'b1, 1'b1, 4'hf, 8'h20, 32'hfeed_0020, 1'b1, 8'h20));
        send_req(make_req(1'b0, 1'b1, 1'b0, 4'h0, 8'h20, 32'h0, 1'b1, 8'h20));
        drain("dual port read");
    endtask

    task automatic test_credit_backpressure();
        int base_resp;
        int base_credit;
        base_resp   = resp_count;
        base_credit = req_credit_count;
        for (int i = 0; i < QUEUE_DEPTH; i++) begin
            send_req(make_req(1'(i), 1'b1, 1'b0, 4'h0, 8'(8'h40 + i), 32'h0, 1'b1,
                              8'(8'hc0 + i)));
        end
        repeat (40) @(negedge clk_in);
        check_value(64'(resp_count - base_resp), 64'd0, "responses without credits");
        check_value(64'(req_credit_count - base_credit), 64'd0, "req_credit while stalled");
        for (int i = 0; i < QUEUE_DEPTH; i++) begin
            pulse_resp_credit();
        end
        drain("credit back-pressure");
        check_value(64'(resp_count - base_resp), 64'(QUEUE_DEPTH), "responses after grant");
        check_value(64'(req_credit_count - base_credit), 64'(QUEUE_DEPTH),
                    "req_credit pulses after grant");
    endtask

    task automatic test_random_traffic();
        mem_req_t r;
        for (int n = 0; n < RANDOM_PACKETS; n++) begin
            r = make_req(1'($urandom_range(1, 0)), 1'($urandom_range(1, 0)),
                         1'($urandom_range(1, 0)), 4'($urandom_range(15, 0)),
                         8'($urandom_range(255, 0)), $urandom,
                         1'($urandom_range(1, 0)), 8'($urandom_range(255, 0)));
            if (resp_credits_out < MAX_RESP_CREDITS && $urandom_range(2, 0) == 0) begin
                pulse_resp_credit();
            end
            send_req(r);
        end
        drain("random traffic");
        check_value(64'(host_credits), 64'(QUEUE_DEPTH), "request credits at end");
    endtask

    initial begin
        void'($urandom(77935));
        clk_in           = 1'b0;
        arst_n           = 1'b0;
        req_valid        = 1'b0;
        req              = '0;
        resp_credit      = 1'b0;
        host_credits     = QUEUE_DEPTH;
        resp_credits_out = 0;
        resp_count       = 0;
        req_credit_count = 0;
        repeat (2) @(posedge clk_in);
        @(negedge clk_in);
        arst_n = 1'b1;
        @(negedge clk_in);
        fill_banks();
        test_bank_isolation();
        test_byte_mask();
        test_dual_port_read();
        test_credit_backpressure();
        test_random_traffic();
        repeat (4) @(negedge clk_in);
        if (u_dut.u_sva.fail_count == 0) begin
            $display("Test passed");
        end else begin
            $display("%0d assertion failures", u_dut.u_sva.fail_count);
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
verilog/sram_pkg.sv
verilog/sram_request_router.sv
verilog/sram_bank.sv
verilog/sram_read_merge.sv
verilog/sram_subsystem.sv
test/sram_subsystem_assertions.sv
test/tb_sram_subsystem.sv

// File: Makefile
TOOL      = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
LINT      = --lint-only -Wall --timing --assert
TOP       = tb_sram_subsystem
RTL_TOP   = sram_subsystem
FILELIST  = filelist.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = Test passed

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "pass message not found in $(LOG)"; exit 1; }

lint:
	$(TOOL) $(LINT) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
